/* Makefile */
# Verilator build and run for the rv32 load/store subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it into sim.log, check the result"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_rv32_lsu -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim 2>&1 | tee sim.log
	@grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+.
rv32_pkg.sv
rv32_issue.sv
rv32_memfy.sv
rv32_regfile.sv
rv32_data_ram.sv
rv32_lsu_top.sv
tb_rv32_lsu.sv

/* rv32_data_ram.sv */
/*
 * word wide data RAM with byte strobes, answering every request after a
 * fixed number of cycles
 */
`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_data_ram #(
    parameter int LATENCY = `RAM_LATENCY
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                mem_en,
    input  logic                mem_wr,
    input  logic [`ADDRW-1:0]   mem_addr,
    input  logic [`XLEN-1:0]    mem_wdata,
    input  logic [`XLEN/8-1:0]  mem_strb,
    output logic [`XLEN-1:0]    mem_rdata,
    output logic                mem_ready
);

    localparam int DEPTH = 1 << (`ADDRW - 2);
    localparam int CNT_W = $clog2(LATENCY + 1);

    logic [`XLEN-1:0]  mem [DEPTH];
    logic [CNT_W-1:0]  cnt;
    logic [`ADDRW-3:0] word_idx;
    logic              fire;

    assign word_idx = mem_addr[`ADDRW-1:2];

    // last waiting cycle, mem_ready follows at the next edge
    assign fire = mem_en && !mem_ready && (cnt == CNT_W'(LATENCY - 1));

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // latency counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt       <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= fire;
            if (mem_ready) begin
                cnt <= '0;
            end else if (mem_en) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (fire && !mem_wr) begin
            mem_rdata <= mem[word_idx];
        end
        // store lands on the edge closing the mem_ready cycle
        if (mem_en && mem_ready && mem_wr) begin
            for (int b = 0; b < `XLEN/8; b++) begin
                if (mem_strb[b]) begin
                    mem[word_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

    a_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_en && !mem_ready |=> mem_en && $stable(mem_wr) && $stable(mem_addr)
                                 && $stable(mem_wdata) && $stable(mem_strb));

endmodule

/* rv32_defs.svh */
/*
 * rv32 load/store subsystem constants: data and address widths, RAM latency,
 * opcodes, funct3 access codes and instruction field positions
 */
`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

////////////////////////////////////////////////////////////
// data path and memory sizing
////////////////////////////////////////////////////////////

`define XLEN        32
// byte address width of the data RAM, 12 bits is 4 KB
`define ADDRW       12
// cycles from the first mem_en cycle to mem_ready, never below 1
`define RAM_LATENCY 2

////////////////////////////////////////////////////////////
// opcodes and funct3 access codes
////////////////////////////////////////////////////////////

`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_LUI     7'b0110111

`define F3_B        3'b000
`define F3_H        3'b001
`define F3_W        3'b010
`define F3_BU       3'b100
`define F3_HU       3'b101

////////////////////////////////////////////////////////////
// instruction field positions and widths
////////////////////////////////////////////////////////////

`define OPCODE_LSB   0
`define OPCODE_W     7
`define RD_LSB       7
`define RD_W         5
`define FUNCT3_LSB   12
`define FUNCT3_W     3
`define RS1_LSB      15
`define RS1_W        5
`define RS2_LSB      20
`define RS2_W        5
// I-type immediate, and the two halves of the S-type immediate
`define IMM_I_LSB    20
`define IMM_I_W      12
`define IMM_S_LO_LSB 7
`define IMM_S_LO_W   5
`define IMM_S_HI_LSB 25
`define IMM_S_HI_W   7
`define IMM_U_LSB    12
`define IMM_U_W      20

`endif

/* rv32_issue.sv */
/*
 * issue stage: takes one instruction, decodes it and holds it on the
 * memory unit until the retiring pulse
 */
`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_issue
    import rv32_pkg::*;
(
    input  logic         aclk,
    input  logic         aresetn,
    input  logic         inst_valid,
    input  logic [31:0]  inst,
    output logic         inst_ready,
    output logic         memfy_en,
    output inst_fields_t instbus,
    input  logic         memfy_ready
);

    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT3_W-1:0] funct3;
    logic                 busy;
    inst_fields_t         decoded;

    assign opcode = inst[`OPCODE_LSB +: `OPCODE_W];
    assign funct3 = inst[`FUNCT3_LSB +: `FUNCT3_W];

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        decoded     = '0;
        decoded.rd  = inst[`RD_LSB +: `RD_W];
        decoded.rs1 = inst[`RS1_LSB +: `RS1_W];
        decoded.rs2 = inst[`RS2_LSB +: `RS2_W];
        case (opcode)
            `OPC_LOAD:  decoded.op = OP_LOAD;
            `OPC_STORE: decoded.op = OP_STORE;
            `OPC_LUI:   decoded.op = OP_LUI;
            default:    decoded.op = OP_NOP;
        endcase
        case (funct3)
            `F3_B, `F3_BU: decoded.size = SZ_BYTE;
            `F3_H, `F3_HU: decoded.size = SZ_HALF;
            default:       decoded.size = SZ_WORD;
        endcase
        decoded.unsigned_ld = (funct3 == `F3_BU) || (funct3 == `F3_HU);
        // store immediate is split around rd in the encoding
        if (opcode == `OPC_STORE) begin
            decoded.imm12 = {inst[`IMM_S_HI_LSB +: `IMM_S_HI_W],
                             inst[`IMM_S_LO_LSB +: `IMM_S_LO_W]};
        end else begin
            decoded.imm12 = inst[`IMM_I_LSB +: `IMM_I_W];
        end
        decoded.imm20 = inst[`IMM_U_LSB +: `IMM_U_W];
    end

    ////////////////////////////////////////////////////////////
    // capture and hold
    ////////////////////////////////////////////////////////////

    // busy covers the whole life of the instruction in the memory unit
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy <= 1'b0;
        end else if (!busy && inst_valid) begin
            busy <= 1'b1;
        end else if (memfy_ready) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid && inst_ready) begin
            instbus <= decoded;
        end
    end

    assign inst_ready = !busy;
    assign memfy_en   = busy;

endmodule

/* rv32_lsu_top.sv */
/*
 * load/store subsystem top: issue stage, memory unit, register file and
 * data RAM
 */
`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_lsu_top
    import rv32_pkg::*;
(
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              inst_valid,
    input  logic [31:0]       inst,
    output logic              inst_ready,
    output logic              idle,
    input  logic [`RD_W-1:0]  dbg_addr,
    output logic [`XLEN-1:0]  dbg_val
);

    ////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////

    inst_fields_t          instbus;
    logic                  memfy_en;
    logic                  memfy_ready;

    logic [`RS1_W-1:0]     rs1_addr;
    logic [`XLEN-1:0]      rs1_val;
    logic [`RS2_W-1:0]     rs2_addr;
    logic [`XLEN-1:0]      rs2_val;
    logic                  rd_wr;
    logic [`RD_W-1:0]      rd_addr;
    logic [`XLEN-1:0]      rd_val;

    logic                  mem_en;
    logic                  mem_wr;
    logic [`ADDRW-1:0]     mem_addr;
    logic [`XLEN-1:0]      mem_wdata;
    logic [`XLEN/8-1:0]    mem_strb;
    logic [`XLEN-1:0]      mem_rdata;
    logic                  mem_ready;

    rv32_issue u_issue (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_ready  (inst_ready),
        .memfy_en    (memfy_en),
        .instbus     (instbus),
        .memfy_ready (memfy_ready)
    );

    rv32_memfy u_memfy (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .memfy_en    (memfy_en),
        .instbus     (instbus),
        .memfy_ready (memfy_ready),
        .idle        (idle),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .rs2_addr    (rs2_addr),
        .rs2_val     (rs2_val),
        .rd_wr       (rd_wr),
        .rd_addr     (rd_addr),
        .rd_val      (rd_val),
        .mem_en      (mem_en),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_strb    (mem_strb),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready)
    );

    rv32_regfile u_regfile (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val),
        .dbg_addr (dbg_addr),
        .dbg_val  (dbg_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val)
    );

    rv32_data_ram #(
        .LATENCY (`RAM_LATENCY)
    ) u_data_ram (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .mem_en    (mem_en),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_strb  (mem_strb),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

endmodule

/* rv32_memfy.sv */
/*
 * memory execution unit: loads, stores and LUI, with byte lane steering
 * on stores and sign or zero extension on loads
 */
`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_memfy
    import rv32_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    // instruction from the issue stage
    input  logic                  memfy_en,
    input  inst_fields_t          instbus,
    output logic                  memfy_ready,
    output logic                  idle,
    // register file
    output logic [`RS1_W-1:0]     rs1_addr,
    input  logic [`XLEN-1:0]      rs1_val,
    output logic [`RS2_W-1:0]     rs2_addr,
    input  logic [`XLEN-1:0]      rs2_val,
    output logic                  rd_wr,
    output logic [`RD_W-1:0]      rd_addr,
    output logic [`XLEN-1:0]      rd_val,
    // data RAM
    output logic                  mem_en,
    output logic                  mem_wr,
    output logic [`ADDRW-1:0]     mem_addr,
    output logic [`XLEN-1:0]      mem_wdata,
    output logic [`XLEN/8-1:0]    mem_strb,
    input  logic [`XLEN-1:0]      mem_rdata,
    input  logic                  mem_ready
);

    logic                 mem_access;
    logic                 memorying;
    logic [`XLEN-1:0]     addr;
    logic [1:0]           lane;
    logic [`XLEN/8-1:0]   strb_base;
    logic [`XLEN-1:0]     rdata_shift;
    logic [`XLEN-1:0]     load_val;

    assign mem_access = (instbus.op == OP_LOAD) || (instbus.op == OP_STORE);

    ////////////////////////////////////////////////////////////
    // access control
    ////////////////////////////////////////////////////////////

    // set after the first cycle of an access and cleared with mem_ready
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            memorying <= 1'b0;
        end else if (memorying) begin
            if (mem_ready) begin
                memorying <= 1'b0;
            end
        end else if (mem_en) begin
            memorying <= 1'b1;
        end
    end

    // LUI and no-ops retire in the first cycle
    assign memfy_ready = memfy_en && (!mem_access || (memorying && mem_ready));
    assign idle        = !memorying;

    ////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////

    assign addr = rs1_val + {{(`XLEN-12){instbus.imm12[11]}}, instbus.imm12};
    assign lane = addr[1:0];

    assign mem_en   = memfy_en && mem_access;
    assign mem_wr   = (instbus.op == OP_STORE);
    assign mem_addr = {addr[`ADDRW-1:2], 2'b00};

    always_comb begin
        case (instbus.size)
            SZ_BYTE: begin
                strb_base = {{(`XLEN/8-1){1'b0}}, 1'b1};
                mem_wdata = {(`XLEN/8){rs2_val[7:0]}};
            end
            SZ_HALF: begin
                strb_base = {{(`XLEN/8-2){1'b0}}, 2'b11};
                mem_wdata = {(`XLEN/16){rs2_val[15:0]}};
            end
            default: begin
                strb_base = '1;
                mem_wdata = rs2_val;
            end
        endcase
    end

    assign mem_strb = mem_wr ? (strb_base << lane) : '0;

    ////////////////////////////////////////////////////////////
    // register side
    ////////////////////////////////////////////////////////////

    assign rs1_addr = instbus.rs1;
    assign rs2_addr = instbus.rs2;
    assign rd_addr  = instbus.rd;

    // addressed lane moved down to bit 0
    assign rdata_shift = mem_rdata >> {lane, 3'b000};

    always_comb begin
        case (instbus.size)
            SZ_BYTE: load_val = {{(`XLEN-8){!instbus.unsigned_ld && rdata_shift[7]}},
                                 rdata_shift[7:0]};
            SZ_HALF: load_val = {{(`XLEN-16){!instbus.unsigned_ld && rdata_shift[15]}},
                                 rdata_shift[15:0]};
            default: load_val = mem_rdata;
        endcase
    end

    always_comb begin
        case (instbus.op)
            OP_LUI:  rd_val = {instbus.imm20, 12'b0};
            OP_LOAD: rd_val = load_val;
            default: rd_val = '0;
        endcase
    end

    assign rd_wr = memfy_en && ((instbus.op == OP_LUI) ||
                                (instbus.op == OP_LOAD && memorying && mem_ready));

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_instbus_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        memorying |-> $stable(instbus));

    // misaligned accesses are not supported
    a_half_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_en && instbus.size == SZ_HALF |-> !addr[0]);

    a_word_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_en && instbus.size == SZ_WORD |-> addr[1:0] == 2'b00);

    a_ready_needs_en: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_ready |-> mem_en);

endmodule

/* rv32_pkg.sv */
/*
 * rv32 load/store types: decoded instruction bus and operation enums
 */
package rv32_pkg;

    // operation class seen by the memory unit
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_LUI   = 2'd2,
        OP_NOP   = 2'd3
    } rv_op_e;

    // access width, taken from funct3
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    // imm12 holds the I immediate for loads, the rebuilt S immediate for stores
    typedef struct packed {
        rv_op_e      op;
        mem_size_e   size;
        logic        unsigned_ld;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
    } inst_fields_t;

endpackage

/* rv32_regfile.sv */
/*
 * 32 entry integer register file, two read ports, one write port and a
 * debug read port, x0 reads zero
 */
`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_regfile (
    input  logic               aclk,
    input  logic               aresetn,
    // source operands
    input  logic [`RS1_W-1:0]  rs1_addr,
    output logic [`XLEN-1:0]   rs1_val,
    input  logic [`RS2_W-1:0]  rs2_addr,
    output logic [`XLEN-1:0]   rs2_val,
    // debug read
    input  logic [`RD_W-1:0]   dbg_addr,
    output logic [`XLEN-1:0]   dbg_val,
    // write back
    input  logic               rd_wr,
    input  logic [`RD_W-1:0]   rd_addr,
    input  logic [`XLEN-1:0]   rd_val
);

    logic [`XLEN-1:0] regs [32];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && rd_addr != '0) begin
            // writes to x0 are dropped, so x0 keeps its reset value
            regs[rd_addr] <= rd_val;
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];
    assign dbg_val = regs[dbg_addr];

    a_rd_addr_known: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr |-> !$isunknown(rd_addr));

endmodule

/* tb_rv32_lsu_model.svh */
/*
 * testbench reference model: register and byte memory images, updated
 * one retired instruction at a time
 */
`ifndef TB_RV32_LSU_MODEL_SVH
`define TB_RV32_LSU_MODEL_SVH

logic [31:0] model_regs [32];
logic [7:0]  model_mem  [1 << `ADDRW];

// registers start cleared by reset, the RAM is zero from time 0
function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = 32'h0;
    end
    for (int i = 0; i < (1 << `ADDRW); i++) begin
        model_mem[i] = 8'h00;
    end
endfunction

// value register idx should hold after the instructions applied so far
function automatic logic [31:0] expected_reg(input int idx);
    if (idx == 0) begin
        return 32'h0;
    end
    return model_regs[idx];
endfunction

function automatic void model_exec(input logic [31:0] word);
    logic [6:0]        opcode;
    logic [4:0]        rd;
    logic [2:0]        f3;
    logic [11:0]       imm;
    logic [31:0]       data;
    logic [`ADDRW-1:0] a;
    opcode = word[6:0];
    rd     = word[11:7];
    f3     = word[14:12];
    data   = model_regs[word[24:20]];
    imm    = (opcode == `OPC_STORE) ? {word[31:25], word[11:7]} : word[31:20];
    // byte address wraps inside the RAM
    a      = `ADDRW'(model_regs[word[19:15]] + {{20{imm[11]}}, imm});
    case (opcode)
        `OPC_LUI: model_regs[rd] = {word[31:12], 12'h000};
        `OPC_LOAD: begin
            case (f3)
                `F3_B:   model_regs[rd] = {{24{model_mem[a][7]}}, model_mem[a]};
                `F3_BU:  model_regs[rd] = {24'h0, model_mem[a]};
                `F3_H:   model_regs[rd] = {{16{model_mem[a+1][7]}}, model_mem[a+1], model_mem[a]};
                `F3_HU:  model_regs[rd] = {16'h0, model_mem[a+1], model_mem[a]};
                default: model_regs[rd] = {model_mem[a+3], model_mem[a+2],
                                           model_mem[a+1], model_mem[a]};
            endcase
        end
        `OPC_STORE: begin
            model_mem[a] = data[7:0];
            if (f3 != `F3_B) begin
                model_mem[a+1] = data[15:8];
            end
            if (f3 == `F3_W) begin
                model_mem[a+2] = data[23:16];
                model_mem[a+3] = data[31:24];
            end
        end
        default: ;
    endcase
    model_regs[0] = 32'h0;
endfunction

`endif

/* tb_rv32_lsu.sv */
/*
 * testbench for the rv32 load/store subsystem: directed and random
 * instruction streams checked against a register and memory model
 */
`timescale 1ns/1ps

`include "rv32_defs.svh"

module tb_rv32_lsu;

    localparam int          WAIT_LIMIT = 64;
    localparam int          RANDOM_OPS = 300;
    localparam logic [11:0] WIN        = 12'h200;

    logic        aclk;
    logic        aresetn;
    logic        inst_valid;
    logic [31:0] inst;
    logic        inst_ready;
    logic        idle;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_val;

    logic  check_go;
    string cur_test;
    int    err_count;
    int    err_base;
    int    tests_run;
    int    tests_failed;

    `include "tb_rv32_lsu_model.svh"

    rv32_lsu_top u_dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .idle       (idle),
        .dbg_addr   (dbg_addr),
        .dbg_val    (dbg_val)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    ////////////////////////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm20);
        return {imm20, rd, `OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm12);
        return {imm12, rs1, f3, rd, `OPC_LOAD};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [11:0] imm12);
        return {imm12[11:5], rs2, rs1, f3, imm12[4:0], `OPC_STORE};
    endfunction

    ////////////////////////////////////////////////////////////
    // checking and bookkeeping
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("test %s: %s", cur_test, reason);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed + 1, err_count);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = err_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (err_count == err_base) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d mismatches", cur_test, err_count - err_base);
            tests_failed++;
        end
    endtask

    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        while (!inst_ready) begin
            @(negedge aclk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run({"inst_ready stayed low ", what});
            end
        end
    endtask

    // issue one instruction, let it retire, then compare every register
    task automatic run_inst(input logic [31:0] word);
        int cycles;
        wait_ready("before issue");
        inst_valid = 1'b1;
        inst       = word;
        @(negedge aclk);
        inst_valid = 1'b0;
        wait_ready("after issue, the instruction never retired");
        model_exec(word);
        check_go <= 1'b1;
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("the register compare did not finish");
            end
        end while (check_go);
    endtask

    // compare process, one register per cycle through the debug port
    initial begin
        forever begin
            @(negedge aclk);
            if (check_go) begin
                for (int i = 0; i < 32; i++) begin
                    dbg_addr = 5'(i);
                    @(negedge aclk);
                    check_value($sformatf("%s x%0d", cur_test, i), expected_reg(i), dbg_val);
                end
                check_go <= 1'b0;
            end
        end
    end

    // a retired instruction leaves no access pending
    always @(negedge aclk) begin
        if (aresetn && inst_ready) begin
            check_value({cur_test, " idle while ready"}, 32'h1, {31'h0, idle});
        end
    end

    task automatic random_ops(input int count);
        int          kind;
        logic [4:0]  r_a;
        logic [4:0]  r_b;
        logic [11:0] off;
        for (int n = 0; n < count; n++) begin
            kind = $urandom_range(0, 8);
            r_a  = 5'($urandom_range(0, 31));
            r_b  = 5'($urandom_range(0, 31));
            off  = 12'($urandom_range(0, 63));
            case (kind)
                0: run_inst(enc_lui(r_a, 20'($urandom)));
                1: run_inst(enc_load(`F3_B, r_a, 5'd0, WIN + off));
                2: run_inst(enc_load(`F3_BU, r_a, 5'd0, WIN + off));
                3: run_inst(enc_load(`F3_H, r_a, 5'd0, WIN + (off & 12'hffe)));
                4: run_inst(enc_load(`F3_HU, r_a, 5'd0, WIN + (off & 12'hffe)));
                5: run_inst(enc_load(`F3_W, r_a, 5'd0, WIN + (off & 12'hffc)));
                6: run_inst(enc_store(`F3_B, 5'd0, r_b, WIN + off));
                7: run_inst(enc_store(`F3_H, 5'd0, r_b, WIN + (off & 12'hffe)));
                default: run_inst(enc_store(`F3_W, 5'd0, r_b, WIN + (off & 12'hffc)));
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h5e95));
        aresetn      = 1'b0;
        inst_valid   = 1'b0;
        inst         = 32'h0;
        dbg_addr     = 5'd0;
        check_go     = 1'b0;
        cur_test     = "reset";
        err_count    = 0;
        err_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_reset();
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        start_test("lui");
        run_inst(enc_lui(5'd1, 20'h12345));
        run_inst(enc_lui(5'd0, 20'hfffff));
        end_test();

        // second pair uses base 0x1000 and a negative offset
        start_test("store_load_word");
        run_inst(enc_lui(5'd2, 20'hcafeb));
        run_inst(enc_store(`F3_W, 5'd0, 5'd2, 12'h040));
        run_inst(enc_load(`F3_W, 5'd3, 5'd0, 12'h040));
        run_inst(enc_lui(5'd5, 20'h00001));
        run_inst(enc_lui(5'd6, 20'h8765a));
        run_inst(enc_store(`F3_W, 5'd5, 5'd6, 12'hff0));
        run_inst(enc_load(`F3_W, 5'd7, 5'd5, 12'hff0));
        end_test();

        start_test("byte_half_lanes");
        run_inst(enc_lui(5'd9, 20'h12345));
        run_inst(enc_store(`F3_W, 5'd0, 5'd9, 12'h090));
        run_inst(enc_load(`F3_HU, 5'd10, 5'd0, 12'h092));
        run_inst(enc_store(`F3_W, 5'd0, 5'd2, 12'h080));
        for (int lane = 0; lane < 4; lane++) begin
            run_inst(enc_store(`F3_B, 5'd0, 5'd10, 12'h080 + 12'(lane)));
            run_inst(enc_load(`F3_W, 5'd11, 5'd0, 12'h080));
        end
        run_inst(enc_store(`F3_W, 5'd0, 5'd2, 12'h084));
        run_inst(enc_store(`F3_H, 5'd0, 5'd10, 12'h084));
        run_inst(enc_load(`F3_W, 5'd11, 5'd0, 12'h084));
        run_inst(enc_store(`F3_H, 5'd0, 5'd10, 12'h086));
        run_inst(enc_load(`F3_W, 5'd11, 5'd0, 12'h084));
        end_test();

        start_test("load_extend");
        run_inst(enc_lui(5'd12, 20'hf8f80));
        run_inst(enc_store(`F3_W, 5'd0, 5'd12, 12'h0a0));
        run_inst(enc_load(`F3_BU, 5'd13, 5'd0, 12'h0a3));
        run_inst(enc_store(`F3_B, 5'd0, 5'd13, 12'h0a0));
        run_inst(enc_load(`F3_B, 5'd14, 5'd0, 12'h0a3));
        run_inst(enc_load(`F3_BU, 5'd15, 5'd0, 12'h0a3));
        run_inst(enc_load(`F3_H, 5'd16, 5'd0, 12'h0a2));
        run_inst(enc_load(`F3_HU, 5'd17, 5'd0, 12'h0a2));
        run_inst(enc_load(`F3_B, 5'd18, 5'd0, 12'h0a0));
        run_inst(enc_load(`F3_H, 5'd19, 5'd0, 12'h0a0));
        end_test();

        // ADDI, ADD and an all-ones word all retire as no-ops
        start_test("unsupported_opcode");
        run_inst(32'h00100093);
        run_inst(32'h003100b3);
        run_inst(32'hffffffff);
        end_test();

        start_test("random");
        random_ops(RANDOM_OPS);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
